// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := dcache_tb
FILELIST := dcache_top.f
BUILD    := obj_dir
LOG      := sim.log
RUNFLAGS := +verilator+error+limit+100

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/dcache_sva.sv
`timescale 1ns/100ps

module dcache_sva (
    input logic                    clock,
    input logic                    reset_n,
    input logic                    req_valid,
    input logic                    req_ready,
    input logic                    req_write,
    input logic                    resp_done,
    input logic                    mem_valid,
    input logic                    mem_ready,
    input logic                    mem_write,
    input dcache_pkg::addr_t       mem_addr,
    input dcache_pkg::line_t       mem_wdata,
    input logic                    ts_hit,
    input dcache_pkg::ctrl_state_t state
);
    import dcache_pkg::*;

    int   error_count = 0;   // polled by the testbench
    logic accept;

    assign accept = req_valid && req_ready;

    // request fields frozen until mem_ready
    a_mem_hold: assert property (@(posedge clock) disable iff (!reset_n)
        $past(mem_valid && !mem_ready) |->
            mem_valid && mem_write == $past(mem_write) && mem_addr == $past(mem_addr) &&
            (!mem_write || mem_wdata == $past(mem_wdata)))
        else begin
            $error("memory request changed while mem_ready was low");
            error_count++;
        end

    a_done_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        $past(resp_done) |-> !resp_done)
        else begin
            $error("resp_done held for more than one cycle");
            error_count++;
        end

    a_busy_on_mem: assert property (@(posedge clock) disable iff (!reset_n)
        mem_valid |-> !req_ready && (state == write_back || state == fetch))
        else begin
            $error("mem_valid outside write_back or fetch");
            error_count++;
        end

    a_read_hit_time: assert property (@(posedge clock) disable iff (!reset_n)
        $past(accept && !req_write, 3) && $past(ts_hit, 2) |-> resp_done)
        else begin
            $error("read hit did not finish 3 cycles after accept");
            error_count++;
        end

    a_write_hit_time: assert property (@(posedge clock) disable iff (!reset_n)
        $past(accept && req_write, 2) && $past(ts_hit) |-> resp_done)   // store hit
        else begin
            $error("write hit did not finish 2 cycles after accept");
            error_count++;
        end

endmodule

bind dcache_top dcache_sva i_dcache_sva (
    .clock     (clock),
    .reset_n   (reset_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .resp_done (resp_done),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .ts_hit    (ts_hit),
    .state     (i_cache_controller.state)
);

// File: bench/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int num_requests = 400;
    localparam int reset_cycles = 5;
    localparam int period_ns    = 4;
    localparam int timeout_ns   = (num_requests * 30 + reset_cycles) * period_ns;

    logic  clock = 1'b0;
    logic  reset_n;
    logic  req_valid;
    logic  req_ready;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    mask_t req_wmask;
    logic  resp_done;
    word_t resp_rdata;
    logic  mem_valid;
    logic  mem_ready;
    logic  mem_write;
    addr_t mem_addr;
    line_t mem_wdata;
    line_t mem_rdata;
    logic  mem_done;

    integer seed = 32'he90d;
    word_t  ref_mem [addr_t];     // architectural value per word address
    line_t  mem_lines [addr_t];   // memory contents per line address

    dcache_top i_dcache_top (
        .clock      (clock),
        .reset_n    (reset_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .resp_done  (resp_done),
        .resp_rdata (resp_rdata),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_done   (mem_done)
    );

    always #2 clock = ~clock;   // 4 ns period

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // untouched memory holds its own word address in both halves
    function automatic word_t initial_word(input addr_t addr);
        return {3'b000, addr[31:3], 3'b000, addr[31:3]};
    endfunction

    function automatic word_t ref_word(input addr_t addr);
        addr_t key;
        key = {addr[31:3], 3'b000};
        if (ref_mem.exists(key)) begin
            return ref_mem[key];
        end
        return initial_word(key);
    endfunction

    function automatic line_t read_line(input addr_t line_addr);
        line_t line;
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        for (int b = 0; b < num_banks; b++) begin
            line[b*64 +: 64] = initial_word(line_addr + addr_t'(b * 8));
        end
        return line;
    endfunction

    // 4 tags x 4 sets x 8 banks so each set sees more lines than ways
    function automatic addr_t make_addr(input logic [31:0] r);
        return {18'h000a3, r[1:0], r[3:2], 4'h5, r[6:4], 3'b000};
    endfunction

    task automatic fail_and_stop();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t expected);
        assert (got === expected) else begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
            fail_and_stop();
        end
    endtask

    // starts and ends just after a rising edge
    task automatic run_request(input logic write, input addr_t addr, input word_t data,
                               input mask_t mask);
        addr_t key;
        word_t merged;
        key       = {addr[31:3], 3'b000};
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        req_wmask = mask;
        @(negedge clock);
        while (!req_ready) @(negedge clock);
        @(posedge clock);
        #0.5;
        req_valid = 1'b0;
        @(negedge clock);
        while (!resp_done) @(negedge clock);
        if (write) begin
            check_word("write response data", resp_rdata, '0);
            merged = ref_word(addr);
            for (int i = 0; i < 64; i++) begin
                if (mask[i]) begin
                    merged[i] = data[i];   // enabled bits take the new data
                end
            end
            ref_mem[key] = merged;
        end else begin
            check_word("read data", resp_rdata, ref_word(addr));
        end
        @(posedge clock);
        #0.5;
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic        write;
        addr_t       addr;
        addr_t       last_write;
        reset_n    = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_wmask  = '0;
        last_write = make_addr(32'd0);
        repeat (reset_cycles) @(posedge clock);
        #0.5;
        reset_n = 1'b1;
        @(negedge clock);
        assert (req_ready && !resp_done && !mem_valid) else begin
            $display("outputs are not idle after reset");
            fail_and_stop();
        end
        @(posedge clock);
        #0.5;
        for (int n = 0; n < num_requests; n++) begin
            r     = next_random();
            write = (n % 2 == 0);
            if (write) begin
                addr       = make_addr(r);
                last_write = addr;
            end else begin
                addr = r[7] ? last_write : make_addr(r);   // often reread the last store
            end
            run_request(write, addr, {next_random(), next_random()},
                        {next_random(), next_random()});
            if (r[9:8] == 2'b00) begin
                @(posedge clock);   // idle gap now and then
                #0.5;
            end
        end
        if (i_dcache_top.i_dcache_sva.error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_and_stop();
        end
    end

    // line memory that samples at the falling edge and answers after the rising edge
    initial begin : memory_model
        logic        take;
        logic        pending;
        logic        pend_write;
        addr_t       pend_addr;
        line_t       pend_line;
        int          delay;
        logic [31:0] r;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        mem_done   = 1'b0;
        pending    = 1'b0;
        pend_write = 1'b0;
        pend_addr  = '0;
        pend_line  = '0;
        delay      = 0;
        forever begin
            @(negedge clock);
            r    = next_random();
            take = reset_n && mem_valid && mem_ready;   // handshake at the coming edge
            if (take) begin
                pend_write = mem_write;
                pend_addr  = mem_addr;
                pend_line  = mem_wdata;
            end
            @(posedge clock);
            #0.5;
            mem_done  = 1'b0;
            mem_rdata = '0;
            if (take) begin
                assert (!pending) else begin
                    $display("memory request issued while another was outstanding");
                    fail_and_stop();
                end
                assert (pend_addr[5:0] == 6'd0) else begin
                    $display("memory address %h is not line aligned", pend_addr);
                    fail_and_stop();
                end
                if (pend_write) begin
                    for (int b = 0; b < num_banks; b++) begin
                        check_word("write-back word", pend_line[b*64 +: 64],
                                   ref_word(pend_addr + addr_t'(b * 8)));
                    end
                    mem_lines[pend_addr] = pend_line;
                end
                pending = 1'b1;
                delay   = int'(r[3:2]);   // done 1 to 4 cycles after the handshake
            end
            if (pending) begin
                if (delay == 0) begin
                    mem_done = 1'b1;
                    if (!pend_write) begin
                        mem_rdata = read_line(pend_addr);
                    end
                    pending = 1'b0;
                end else begin
                    delay--;
                end
            end
            mem_ready = (r[1:0] != 2'b00);   // withheld about one cycle in four
        end
    end

    always @(negedge clock) begin
        assert (i_dcache_top.i_dcache_sva.error_count == 0) else begin
            $display("a protocol assertion in dcache_sva failed");
            fail_and_stop();
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout: the requests did not finish within %0d ns", timeout_ns);
        fail_and_stop();
    end

endmodule

// File: dcache_top.f
rtl/dcache_pkg.sv
rtl/tag_store.sv
rtl/data_store.sv
rtl/cache_controller.sv
rtl/dcache_top.sv
bench/dcache_sva.sv
bench/dcache_tb.sv

// File: rtl/cache_controller.sv
`timescale 1ns/100ps

module cache_controller (
    input  logic                clock,
    input  logic                reset_n,
    // request side
    input  logic                req_valid,
    output logic                req_ready,
    input  logic                req_write,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::word_t   req_wdata,
    input  dcache_pkg::mask_t   req_wmask,
    output logic                resp_done,
    output dcache_pkg::word_t   resp_rdata,
    // memory side
    output logic                mem_valid,
    input  logic                mem_ready,
    output logic                mem_write,
    output dcache_pkg::addr_t   mem_addr,
    output dcache_pkg::line_t   mem_wdata,
    input  dcache_pkg::line_t   mem_rdata,
    input  logic                mem_done,
    // tag store
    output dcache_pkg::index_t  set_index,
    output logic                ts_lookup,
    output dcache_pkg::tag_t    ts_tag,
    output logic                ts_mark_dirty,
    output logic                ts_fill,
    output logic                ts_fill_dirty,
    input  logic                ts_hit,
    input  dcache_pkg::way_t    ts_hit_way,
    input  dcache_pkg::way_t    ts_victim_way,
    input  logic                ts_victim_dirty,
    input  dcache_pkg::tag_t    ts_victim_tag,
    // data store
    output dcache_pkg::way_t    ds_way,
    output dcache_pkg::bank_t   ds_bank,
    output logic                ds_read,
    output logic                ds_word_write,
    output logic                ds_line_write,
    output dcache_pkg::word_t   ds_wdata,
    output dcache_pkg::mask_t   ds_wmask,
    output dcache_pkg::line_t   ds_line_in,
    input  dcache_pkg::line_t   ds_line_out
);
    import dcache_pkg::*;

    localparam int word_bits = $bits(word_t);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        rd_phase;      // second cycle of read_cache
    logic        accept;
    logic        issue_wb;
    logic        issue_fetch;

    logic        req_write_q;
    addr_t       req_addr_q;
    word_t       req_wdata_q;
    mask_t       req_wmask_q;
    line_t       fill_line;

    addr_t       cur_addr;
    bank_t       cur_bank;
    word_t       hit_word;
    word_t       fill_word;

    assign req_ready = (state == idle);
    assign accept    = req_valid & req_ready;

    // lookup is launched straight from the request port
    assign cur_addr  = (state == idle) ? req_addr : req_addr_q;
    assign set_index = cur_addr[offset_bits +: index_bits];
    assign ts_tag    = cur_addr[31 -: tag_bits];
    assign cur_bank  = cur_addr[offset_bits-1 -: $bits(bank_t)];

    always_ff @(posedge clock) begin
        if (accept) begin
            req_write_q <= req_write;
            req_addr_q  <= req_addr;
            req_wdata_q <= req_wdata;
            req_wmask_q <= req_wmask;
        end
        if (state == fetch && mem_done) begin
            fill_line <= mem_rdata;   // only valid in the done cycle
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= idle;
            rd_phase <= 1'b0;
        end else begin
            state    <= next_state;
            rd_phase <= (state == read_cache) && !rd_phase;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle:        if (req_valid) next_state = lookup;
            lookup: begin
                if (ts_hit) begin
                    next_state = req_write_q ? write_cache : read_cache;
                end else if (ts_victim_dirty) begin
                    next_state = read_cache;   // victim line out first
                end else begin
                    next_state = fetch;
                end
            end
            read_cache:  if (rd_phase) next_state = ts_hit ? idle : write_back;
            write_cache: next_state = idle;
            write_back:  if (mem_done) next_state = fetch;
            fetch:       if (mem_done) next_state = refill;
            refill:      next_state = idle;
            default:     next_state = idle;
        endcase
    end

    // store strobes
    assign ts_lookup     = accept;
    assign ts_mark_dirty = (state == write_cache);
    assign ts_fill       = (state == refill);
    assign ts_fill_dirty = req_write_q;

    assign ds_way        = ts_hit ? ts_hit_way : ts_victim_way;
    assign ds_bank       = cur_bank;
    assign ds_read       = (state == read_cache) && !rd_phase;
    assign ds_word_write = (state == write_cache) || (state == refill && req_write_q);
    assign ds_line_write = (state == refill);
    assign ds_wdata      = req_wdata_q;
    assign ds_wmask      = req_wmask_q;
    assign ds_line_in    = fill_line;

    assign issue_wb    = (state == read_cache) && rd_phase && !ts_hit;
    assign issue_fetch = (state == lookup && !ts_hit && !ts_victim_dirty) ||
                         (state == write_back && mem_done);

    // valid held until mem_ready, then dropped
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_valid <= 1'b0;
        end else if (issue_wb || issue_fetch) begin
            mem_valid <= 1'b1;
        end else if (mem_ready) begin
            mem_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_wb) begin
            mem_write <= 1'b1;
            mem_addr  <= {ts_victim_tag, set_index, {offset_bits{1'b0}}};
            mem_wdata <= ds_line_out;
        end else if (issue_fetch) begin
            mem_write <= 1'b0;
            mem_addr  <= {cur_addr[31:offset_bits], {offset_bits{1'b0}}};
        end
    end

    assign hit_word  = ds_line_out[int'(cur_bank) * word_bits +: word_bits];
    assign fill_word = fill_line[int'(cur_bank) * word_bits +: word_bits];

    assign resp_done = (state == write_cache) || (state == refill) ||
                       (state == read_cache && rd_phase && ts_hit);

    always_comb begin
        resp_rdata = '0;   // writes return zero
        if (state == read_cache && rd_phase && ts_hit) begin
            resp_rdata = hit_word;
        end else if (state == refill && !req_write_q) begin
            resp_rdata = fill_word;
        end
    end

endmodule

// File: rtl/data_store.sv
`timescale 1ns/100ps

module data_store (
    input  logic               clock,
    input  dcache_pkg::way_t   way,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::bank_t  bank,
    input  logic               read,
    input  logic               word_write,
    input  logic               line_write,
    input  dcache_pkg::word_t  wdata,
    input  dcache_pkg::mask_t  wmask,
    input  dcache_pkg::line_t  line_in,
    output dcache_pkg::line_t  line_out
);
    import dcache_pkg::*;

    localparam int word_bits = $bits(word_t);

    // keep old bits where the mask is clear
    function automatic word_t merge_word(
        input word_t old_word,
        input word_t new_word,
        input mask_t mask
    );
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // one array per bank, both ways side by side
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        word_t mem [num_ways][num_sets];
        word_t base_word;
        word_t next_word;
        word_t rd_word;
        logic  sel;
        logic  wr_en;

        assign sel = (bank == bank_t'(b));

        // a line write starts from the incoming line, a word write from the array
        assign base_word = line_write ? line_in[b*word_bits +: word_bits] : mem[way][index];
        assign next_word = (word_write && sel) ? merge_word(base_word, wdata, wmask)
                                               : base_word;
        assign wr_en     = line_write || (word_write && sel);

        always_ff @(posedge clock) begin
            if (wr_en) begin
                mem[way][index] <= next_word;
            end
            if (read) begin
                rd_word <= mem[way][index];   // whole line is read for write-back
            end
        end

        assign line_out[b*word_bits +: word_bits] = rd_word;
    end

endmodule

// File: rtl/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int num_ways    = 2;
    localparam int num_banks   = 8;    // 64-bit words per line
    localparam int num_sets    = 64;
    localparam int offset_bits = 6;    // 64-byte lines
    localparam int index_bits  = 6;
    localparam int tag_bits    = 32 - index_bits - offset_bits;

    // address split: [31:12] tag, [11:6] index, [5:3] bank, [2:0] ignored
    typedef logic [31:0]                  addr_t;
    typedef logic [tag_bits-1:0]          tag_t;
    typedef logic [index_bits-1:0]        index_t;
    typedef logic [$clog2(num_banks)-1:0] bank_t;
    typedef logic [$clog2(num_ways)-1:0]  way_t;

    typedef logic [63:0] word_t;
    typedef logic [63:0] mask_t;           // one enable per data bit

    // word n sits at bits n*64 upward
    typedef logic [num_banks*64-1:0] line_t;

    // controller FSM
    typedef enum logic [2:0] {
        idle,          // waiting for a request
        lookup,        // tag compare result available
        read_cache,    // two cycles, line read then use
        write_cache,   // store hit
        write_back,    // dirty victim out to memory
        fetch,         // line read from memory
        refill         // line into the cache, response
    } ctrl_state_t;

endpackage

// File: rtl/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              req_write,
    input  dcache_pkg::addr_t req_addr,
    input  dcache_pkg::word_t req_wdata,
    input  dcache_pkg::mask_t req_wmask,
    output logic              resp_done,
    output dcache_pkg::word_t resp_rdata,
    output logic              mem_valid,
    input  logic              mem_ready,
    output logic              mem_write,
    output dcache_pkg::addr_t mem_addr,
    output dcache_pkg::line_t mem_wdata,
    input  dcache_pkg::line_t mem_rdata,
    input  logic              mem_done
);
    import dcache_pkg::*;

    index_t set_index;
    logic   ts_lookup;
    tag_t   ts_tag;
    logic   ts_mark_dirty;
    logic   ts_fill;
    logic   ts_fill_dirty;
    logic   ts_hit;
    way_t   ts_hit_way;
    way_t   ts_victim_way;
    logic   ts_victim_dirty;
    tag_t   ts_victim_tag;

    way_t   ds_way;
    bank_t  ds_bank;
    logic   ds_read;
    logic   ds_word_write;
    logic   ds_line_write;
    word_t  ds_wdata;
    mask_t  ds_wmask;
    line_t  ds_line_in;
    line_t  ds_line_out;

    cache_controller i_cache_controller (
        .clock           (clock),
        .reset_n         (reset_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_write       (req_write),
        .req_addr        (req_addr),
        .req_wdata       (req_wdata),
        .req_wmask       (req_wmask),
        .resp_done       (resp_done),
        .resp_rdata      (resp_rdata),
        .mem_valid       (mem_valid),
        .mem_ready       (mem_ready),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_done        (mem_done),
        .set_index       (set_index),
        .ts_lookup       (ts_lookup),
        .ts_tag          (ts_tag),
        .ts_mark_dirty   (ts_mark_dirty),
        .ts_fill         (ts_fill),
        .ts_fill_dirty   (ts_fill_dirty),
        .ts_hit          (ts_hit),
        .ts_hit_way      (ts_hit_way),
        .ts_victim_way   (ts_victim_way),
        .ts_victim_dirty (ts_victim_dirty),
        .ts_victim_tag   (ts_victim_tag),
        .ds_way          (ds_way),
        .ds_bank         (ds_bank),
        .ds_read         (ds_read),
        .ds_word_write   (ds_word_write),
        .ds_line_write   (ds_line_write),
        .ds_wdata        (ds_wdata),
        .ds_wmask        (ds_wmask),
        .ds_line_in      (ds_line_in),
        .ds_line_out     (ds_line_out)
    );

    tag_store i_tag_store (
        .clock        (clock),
        .reset_n      (reset_n),
        .lookup       (ts_lookup),
        .index        (set_index),
        .tag          (ts_tag),
        .mark_dirty   (ts_mark_dirty),
        .fill         (ts_fill),
        .fill_dirty   (ts_fill_dirty),
        .hit          (ts_hit),
        .hit_way      (ts_hit_way),
        .victim_way   (ts_victim_way),
        .victim_dirty (ts_victim_dirty),
        .victim_tag   (ts_victim_tag)
    );

    data_store i_data_store (
        .clock      (clock),
        .way        (ds_way),
        .index      (set_index),
        .bank       (ds_bank),
        .read       (ds_read),
        .word_write (ds_word_write),
        .line_write (ds_line_write),
        .wdata      (ds_wdata),
        .wmask      (ds_wmask),
        .line_in    (ds_line_in),
        .line_out   (ds_line_out)
    );

endmodule

// File: rtl/tag_store.sv
`timescale 1ns/100ps

module tag_store (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               lookup,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  logic               mark_dirty,
    input  logic               fill,
    input  logic               fill_dirty,
    output logic               hit,
    output dcache_pkg::way_t   hit_way,
    output dcache_pkg::way_t   victim_way,
    output logic               victim_dirty,
    output dcache_pkg::tag_t   victim_tag
);
    import dcache_pkg::*;

    tag_t                tag_mem [num_ways][num_sets];
    logic [num_ways-1:0] valid_mem [num_sets];
    logic [num_ways-1:0] dirty_mem [num_sets];
    logic [7:0]          lfsr;

    logic [num_ways-1:0] set_valid;
    logic [num_ways-1:0] set_dirty;
    logic                any_hit;
    way_t                first_hit;
    logic                any_free;
    way_t                first_free;
    way_t                pick;

    assign set_valid = valid_mem[index];
    assign set_dirty = dirty_mem[index];

    // scan downward so the lowest way wins
    always_comb begin
        any_hit    = 1'b0;
        first_hit  = '0;
        any_free   = 1'b0;
        first_free = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (set_valid[w] && tag_mem[w][index] == tag) begin
                any_hit   = 1'b1;
                first_hit = way_t'(w);
            end
            if (!set_valid[w]) begin
                any_free   = 1'b1;
                first_free = way_t'(w);
            end
        end
    end

    // full set falls back to the pseudo random way
    assign pick = any_free ? first_free : way_t'(lfsr[0]);

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= 8'hff;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // lookup result, held until the next lookup
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            hit          <= 1'b0;
            hit_way      <= '0;
            victim_way   <= '0;
            victim_dirty <= 1'b0;
        end else if (lookup) begin
            hit          <= any_hit;
            hit_way      <= first_hit;
            victim_way   <= pick;
            victim_dirty <= set_valid[pick] & set_dirty[pick];
        end
    end

    always_ff @(posedge clock) begin
        if (lookup) begin
            victim_tag <= tag_mem[pick][index];   // for the write-back address
        end
        if (fill) begin
            tag_mem[victim_way][index] <= tag;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
        end else if (fill) begin
            valid_mem[index][victim_way] <= 1'b1;
            dirty_mem[index][victim_way] <= fill_dirty;   // set on a store miss
        end else if (mark_dirty) begin
            dirty_mem[index][hit_way] <= 1'b1;
        end
    end

endmodule
